/* verilog.f */
src/icache_pkg.sv
src/bram_1r1w.sv
src/icache_lookup.sv
src/icache_ctrl.sv
src/icache_stats.sv
src/icache_top.sv
dv/tb_bus_memory.sv
dv/tb_icache.sv

/* Makefile */
# Verilator build and run of the instruction cache testbench.
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_icache.sv */
// Testbench for the instruction cache top level.
// Fetches random PCs over a few code regions whose sets collide, answers
// misses from a behavioral memory and checks data, bus traffic and the
// statistics against a model of the valid bits and tags.

`timescale 1ns/1ps

module tb_icache;

	localparam int SET_BITS    = 4;
	localparam int NUM_SETS    = 1 << SET_BITS;
	localparam int TAG_BITS    = 30 - SET_BITS;
	localparam int TIMEOUT     = 200;
	localparam int NUM_REGIONS = 4;

	logic                 clock;
	logic                 reset = 1'b1;
	icache_pkg::word_t    pc = '0;
	icache_pkg::word_t    rdata;
	logic                 ready;
	icache_pkg::bus_req_t bus_req;
	icache_pkg::bus_rsp_t bus_rsp;
	icache_pkg::stats_t   stats;
	logic [2:0]           wait_pick = '0;
	icache_pkg::word_t    bus_word;

	logic [31:0]          rand_state = 32'd72;
	logic                 model_valid [NUM_SETS];
	logic [TAG_BITS-1:0]  model_tag [NUM_SETS];
	int                   expect_fetches;
	int                   expect_refills;
	int                   region;
	int                   offset;
	icache_pkg::word_t    region_base [NUM_REGIONS];

	icache_top #(
		.SET_BITS(SET_BITS)
	) dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_pc(pc),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_bus_req(bus_req),
		.i_bus_rsp(bus_rsp),
		.o_stats(stats)
	);

	tb_bus_memory u_memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_bus_req(bus_req),
		.i_wait_cycles(wait_pick),
		.i_word(bus_word),
		.o_bus_rsp(bus_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int draw(input int range);
		rand_state = xorshift32(rand_state);
		return int'(rand_state % 32'(range));
	endfunction

	// Instruction word stored at a byte address, a fixed scramble.
	function automatic icache_pkg::word_t mem_word(input icache_pkg::word_t address);
		logic [31:0] x;
		x = address ^ 32'h5a3c_96e1;
		x = x * 32'h9e37_79b1;
		return x ^ (x >> 15);
	endfunction

	assign bus_word = mem_word(bus_req.address);

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout: no %s within %0d cycles at %0t ns.", what, TIMEOUT, $time);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	endtask

	// Sequential step, jump inside the region, or same offset in another region.
	function automatic icache_pkg::word_t next_pc();
		int choice;
		choice = draw(8);
		if (choice < 5) begin
			offset = (offset + 1) % 32;
		end else if (choice < 7) begin
			offset = draw(32);
		end else begin
			region = (region + 1 + draw(NUM_REGIONS - 1)) % NUM_REGIONS;
		end
		return region_base[region] + 32'(offset * 4);
	endfunction

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		@(posedge clock);
		repeat (3) begin
			@(negedge clock);
			check_value("o_ready", 32'(ready), 32'd0);
			check_value("o_bus_req.request", 32'(bus_req.request), 32'd0);
		end
		@(posedge clock);
		reset <= 1'b0;
		for (int s = 0; s < NUM_SETS; s++) begin
			model_valid[s] = 1'b0;
		end
		expect_fetches = 0;
		expect_refills = 0;
		// Clear sweep, one set per cycle.
		repeat (NUM_SETS) begin
			@(negedge clock);
			check_value("o_ready", 32'(ready), 32'd0);
			check_value("o_bus_req.request", 32'(bus_req.request), 32'd0);
		end
		check_value("o_stats.hits", stats.hits, 32'd0);
		check_value("o_stats.misses", stats.misses, 32'd0);
	endtask

	task automatic fetch(input icache_pkg::word_t address);
		logic [SET_BITS-1:0] set;
		logic [TAG_BITS-1:0] tag;
		logic                expect_hit;
		logic                was_waiting;
		logic                done;
		int                  requests;
		int                  cycles;

		set         = address[icache_pkg::WORD_OFFSET_BITS +: SET_BITS];
		tag         = address[31 -: TAG_BITS];
		expect_hit  = model_valid[set] && (model_tag[set] == tag);
		was_waiting = 1'b0;
		done        = 1'b0;
		requests    = 0;
		cycles      = 0;
		@(posedge clock);
		pc <= address;
		while (!done) begin
			@(negedge clock);
			wait_pick <= 3'(draw(6));
			if (bus_req.request) begin
				if (!was_waiting) begin
					requests++;
				end
				check_value("o_bus_req.address", bus_req.address, address);
			end else if (was_waiting) begin
				check_value("o_bus_req.request", 32'(bus_req.request), 32'd1);
			end
			// Refill completes on this cycle's edge.
			if (bus_req.request && bus_rsp.ready) begin
				model_valid[set] = 1'b1;
				model_tag[set]   = tag;
				expect_refills++;
			end
			was_waiting = bus_req.request && !bus_rsp.ready;
			if (ready) begin
				check_value("o_rdata", rdata, mem_word(address));
				done = 1'b1;
			end else begin
				cycles++;
				if (cycles > TIMEOUT) begin
					fail_timeout("o_ready for the current PC");
				end
			end
		end
		check_value("bus requests for one fetch", 32'(requests), expect_hit ? 32'd0 : 32'd1);
		expect_fetches++;
	endtask

	// Counters update on the edge that accepts the last fetch.
	task automatic check_stats();
		@(posedge clock);
		@(negedge clock);
		check_value("o_stats.hits", stats.hits, 32'(expect_fetches));
		check_value("o_stats.misses", stats.misses, 32'(expect_refills));
	endtask

	// Two PCs on the same set evict each other.
	task automatic conflict_check();
		icache_pkg::word_t first;
		icache_pkg::word_t second;
		logic [31:0]       start_misses;

		first        = region_base[0] + 32'h24;
		second       = region_base[2] + 32'h24;
		start_misses = stats.misses;
		fetch(first);
		fetch(first);
		fetch(second);
		fetch(first);
		check_value("o_stats.misses in conflict sequence",
			stats.misses - start_misses, 32'd3);
	endtask

	initial begin
		region         = 0;
		offset         = 0;
		region_base[0] = 32'h0000_0200;
		region_base[1] = 32'h0000_1200;
		region_base[2] = 32'h0004_0600;
		region_base[3] = 32'h0100_0000;
		apply_reset();
		conflict_check();
		repeat (300) begin
			fetch(next_pc());
		end
		check_stats();
		apply_reset();
		repeat (200) begin
			fetch(next_pc());
		end
		check_stats();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* dv/tb_bus_memory.sv */
// Behavioral memory on the request/ready bus of the instruction cache.
// Each request is answered after i_wait_cycles edges, sampled when the
// request is first seen. The word comes from the testbench on i_word.

`timescale 1ns/1ps

module tb_bus_memory (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  icache_pkg::bus_req_t i_bus_req,
	input  logic [2:0]           i_wait_cycles,
	input  icache_pkg::word_t    i_word,
	output icache_pkg::bus_rsp_t o_bus_rsp
);

	logic       busy = 1'b0;
	logic [2:0] count = '0;
	logic       ready = 1'b0;

	always @(posedge i_clock) begin
		if (i_reset) begin
			busy  <= 1'b0;
			count <= '0;
			ready <= 1'b0;
		end else if (ready) begin
			// The cache drops its request on this same edge.
			ready <= 1'b0;
			busy  <= 1'b0;
		end else if (i_bus_req.request) begin
			if (!busy) begin
				busy  <= 1'b1;
				count <= i_wait_cycles;
				ready <= (i_wait_cycles == 3'd0);
			end else if (count <= 3'd1) begin
				ready <= 1'b1;
			end else begin
				count <= count - 3'd1;
			end
		end
	end

	assign o_bus_rsp.ready = ready;
	assign o_bus_rsp.rdata = ready ? i_word : '0;

endmodule

/* src/icache_top.sv */
// Instruction cache top level, direct mapped with one word per line.
// The fetch unit holds i_pc until o_ready is high. Misses are refilled
// over the request/ready memory bus. SET_BITS sets the number of lines.

`timescale 1ns/1ps

module icache_top #(
	parameter int SET_BITS = 6
)(
	input  logic                  i_clock,
	input  logic                  i_reset,

	// Fetch side.
	input  icache_pkg::word_t     i_pc,
	output icache_pkg::word_t     o_rdata,
	output logic                  o_ready,

	// Memory bus.
	output icache_pkg::bus_req_t  o_bus_req,
	input  icache_pkg::bus_rsp_t  i_bus_rsp,

	output icache_pkg::stats_t    o_stats
);

	localparam int TAG_BITS   = 30 - SET_BITS;
	localparam int ENTRY_BITS = 1 + TAG_BITS + 32;

	logic [SET_BITS-1:0]   rd_set;
	logic [ENTRY_BITS-1:0] rd_entry;
	logic                  hit;
	logic                  miss;
	logic [SET_BITS-1:0]   pc_set;
	logic [TAG_BITS-1:0]   pc_tag;
	logic                  enable;
	logic                  wr_request;
	logic [SET_BITS-1:0]   wr_set;
	logic [ENTRY_BITS-1:0] wr_entry;
	logic                  refill_start;

	bram_1r1w #(
		.WIDTH(ENTRY_BITS),
		.DEPTH(1 << SET_BITS)
	) u_bram (
		.i_clock(i_clock),
		.i_rd_address(rd_set),
		.o_rd_data(rd_entry),
		.i_wr_request(wr_request),
		.i_wr_address(wr_set),
		.i_wr_data(wr_entry)
	);

	icache_lookup #(
		.SET_BITS(SET_BITS)
	) u_lookup (
		.i_clock(i_clock),
		.i_enable(enable),
		.i_pc(i_pc),
		.o_rd_set(rd_set),
		.i_rd_entry(rd_entry),
		.o_hit(hit),
		.o_miss(miss),
		.o_set(pc_set),
		.o_tag(pc_tag),
		.o_rdata(o_rdata)
	);

	icache_ctrl #(
		.SET_BITS(SET_BITS)
	) u_ctrl (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(i_pc),
		.i_miss(miss),
		.i_set(pc_set),
		.i_tag(pc_tag),
		.o_enable(enable),
		.o_bus_req(o_bus_req),
		.i_bus_rsp(i_bus_rsp),
		.o_wr_request(wr_request),
		.o_wr_set(wr_set),
		.o_wr_entry(wr_entry),
		.o_refill_start(refill_start)
	);

	icache_stats u_stats (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_hit(hit),
		.i_refill_start(refill_start),
		.o_stats(o_stats)
	);

	assign o_ready = hit;

endmodule

/* src/icache_stats.sv */
// Hit and miss statistics of the instruction cache.
// Hits count cycles with an accepted fetch, misses count refill starts.
// Both counters wrap and are cleared by reset.

`timescale 1ns/1ps

module icache_stats (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_hit,
	input  logic                i_refill_start,
	output icache_pkg::stats_t  o_stats
);

	logic [31:0] hits;
	logic [31:0] misses;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			hits <= '0;
		end else if (i_hit) begin
			hits <= hits + 32'd1;
		end
	end

	// One count per refill, not per stalled cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			misses <= '0;
		end else if (i_refill_start) begin
			misses <= misses + 32'd1;
		end
	end

	assign o_stats.hits   = hits;
	assign o_stats.misses = misses;

endmodule

/* src/icache_ctrl.sv */
// Control FSM of the instruction cache.
// After reset it sweeps every set to an invalid entry, one set per cycle.
// Afterwards it waits for a lookup miss, fetches the word over the memory
// bus and writes the refilled line into the RAM.

`timescale 1ns/1ps

module icache_ctrl #(
	parameter  int SET_BITS   = 6,
	localparam int TAG_BITS   = 30 - SET_BITS,
	localparam int ENTRY_BITS = 1 + TAG_BITS + 32
)(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  icache_pkg::word_t      i_pc,

	// From the lookup.
	input  logic                   i_miss,
	input  logic [SET_BITS-1:0]    i_set,
	input  logic [TAG_BITS-1:0]    i_tag,
	output logic                   o_enable,

	// Memory bus.
	output icache_pkg::bus_req_t   o_bus_req,
	input  icache_pkg::bus_rsp_t   i_bus_rsp,

	// RAM write port.
	output logic                   o_wr_request,
	output logic [SET_BITS-1:0]    o_wr_set,
	output logic [ENTRY_BITS-1:0]  o_wr_entry,

	output logic                   o_refill_start
);

	typedef struct packed {
		logic                valid;
		logic [TAG_BITS-1:0] tag;
		icache_pkg::word_t   data;
	} entry_t;

	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_IDLE,
		ST_REFILL
	} state_t;

	state_t              state;
	logic [SET_BITS-1:0] clear_count;
	logic                refill_wait;
	logic [SET_BITS-1:0] refill_set;
	logic [TAG_BITS-1:0] refill_tag;
	icache_pkg::word_t   refill_pc;
	entry_t              wr_entry;

	// The RAM output is stale for one cycle after a refill write,
	// so a miss seen in that cycle is not a new miss.
	assign o_refill_start = (state == ST_IDLE) && i_miss && !refill_wait;
	assign o_enable       = (state != ST_CLEAR);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state       <= ST_CLEAR;
			clear_count <= '0;
			refill_wait <= 1'b0;
		end else begin
			refill_wait <= 1'b0;
			case (state)
				ST_CLEAR: begin
					clear_count <= clear_count + SET_BITS'(1);
					if (clear_count == '1) begin
						state <= ST_IDLE;
					end
				end
				ST_IDLE: begin
					if (o_refill_start) begin
						state <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (i_bus_rsp.ready) begin
						state       <= ST_IDLE;
						refill_wait <= 1'b1;
					end
				end
				default: state <= ST_CLEAR;
			endcase
		end
	end

	// Miss context, held for the whole refill.
	always_ff @(posedge i_clock) begin
		if (o_refill_start) begin
			refill_set <= i_set;
			refill_tag <= i_tag;
			refill_pc  <= i_pc;
		end
	end

	assign o_bus_req.request = (state == ST_REFILL);
	assign o_bus_req.address = refill_pc;

	// Sweep writes invalid entries, refill writes on the bus ready cycle.
	always_comb begin
		o_wr_request = 1'b0;
		o_wr_set     = clear_count;
		wr_entry     = '0;

		case (state)
			ST_CLEAR: begin
				o_wr_request = 1'b1;
			end
			ST_REFILL: begin
				o_wr_request   = i_bus_rsp.ready;
				o_wr_set       = refill_set;
				wr_entry.valid = 1'b1;
				wr_entry.tag   = refill_tag;
				wr_entry.data  = i_bus_rsp.rdata;
			end
			default: begin
				o_wr_request = 1'b0;
			end
		endcase
	end

	assign o_wr_entry = wr_entry;

endmodule

/* src/icache_lookup.sv */
// Tag lookup stage of the instruction cache.
// Tracks which set the RAM output belongs to, compares valid bit and tag
// against the current PC and drives the RAM read address. A hit moves the
// read address on to the next set so sequential fetches hit every cycle.

`timescale 1ns/1ps

module icache_lookup #(
	parameter  int SET_BITS   = 6,
	localparam int TAG_BITS   = 30 - SET_BITS,
	localparam int ENTRY_BITS = 1 + TAG_BITS + 32
)(
	input  logic                  i_clock,
	input  logic                  i_enable,
	input  icache_pkg::word_t     i_pc,

	// RAM read port.
	output logic [SET_BITS-1:0]   o_rd_set,
	input  logic [ENTRY_BITS-1:0] i_rd_entry,

	// Lookup result.
	output logic                  o_hit,
	output logic                  o_miss,
	output logic [SET_BITS-1:0]   o_set,
	output logic [TAG_BITS-1:0]   o_tag,
	output icache_pkg::word_t     o_rdata
);

	// Line entry, valid bit on top, then tag, then the instruction word.
	typedef struct packed {
		logic                valid;
		logic [TAG_BITS-1:0] tag;
		icache_pkg::word_t   data;
	} entry_t;

	entry_t              rd_entry;
	logic [SET_BITS-1:0] pc_set;
	logic [TAG_BITS-1:0] pc_tag;
	logic [SET_BITS-1:0] set_r;

	assign rd_entry = i_rd_entry;
	assign pc_set   = i_pc[icache_pkg::WORD_OFFSET_BITS +: SET_BITS];
	assign pc_tag   = i_pc[31 -: TAG_BITS];

	// Set presented to the RAM last cycle, i.e. the set now on its output.
	always_ff @(posedge i_clock) begin
		set_r <= o_rd_set;
	end

	always_comb begin
		o_hit    = 1'b0;
		o_miss   = 1'b0;
		o_rd_set = '0;

		if (i_enable) begin
			o_rd_set = pc_set;
			if (set_r == pc_set) begin
				if (rd_entry.valid && rd_entry.tag == pc_tag) begin
					o_hit    = 1'b1;
					o_rd_set = pc_set + SET_BITS'(1);
				end else begin
					o_miss = 1'b1;
				end
			end
		end
	end

	assign o_set   = pc_set;
	assign o_tag   = pc_tag;
	assign o_rdata = rd_entry.data;

endmodule

/* src/bram_1r1w.sv */
// Simple dual-port block RAM, one synchronous read port and one write port.
// The read port is always enabled and returns data one cycle after the address.
// A write to the address being read on the same edge returns the old content.

`timescale 1ns/1ps

module bram_1r1w #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
)(
	input  logic                     i_clock,

	// Read port.
	input  logic [$clog2(DEPTH)-1:0] i_rd_address,
	output logic [WIDTH-1:0]         o_rd_data,

	// Write port.
	input  logic                     i_wr_request,
	input  logic [$clog2(DEPTH)-1:0] i_wr_address,
	input  logic [WIDTH-1:0]         i_wr_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge i_clock) begin
		if (i_wr_request) begin
			mem[i_wr_address] <= i_wr_data;
		end
	end

	// Registered read, read-first against a write on the same edge.
	always_ff @(posedge i_clock) begin
		o_rd_data <= mem[i_rd_address];
	end

endmodule

/* src/icache_pkg.sv */
// Shared types and constants for the instruction cache.
// Holds the instruction word type, the memory bus request and response
// structs and the statistics struct. Referenced by scoped names only.

package icache_pkg;

	// Instruction word or byte address.
	typedef logic [31:0] word_t;

	// Byte offset bits below the set index of a word-aligned PC.
	localparam int WORD_OFFSET_BITS = 2;

	// Request toward memory, held until the response ready pulse.
	typedef struct packed {
		logic  request;
		word_t address;
	} bus_req_t;

	// Response from memory, ready is high for a single cycle.
	typedef struct packed {
		logic  ready;
		word_t rdata;
	} bus_rsp_t;

	// Hit and miss counters reported by the top level.
	typedef struct packed {
		logic [31:0] hits;
		logic [31:0] misses;
	} stats_t;

endpackage
